//--- hdl/pdp8Pkg.sv
// shared word, state and console types plus timing and opcode constants for the pdp-8 core
package pdp8Pkg;

    localparam int WORD_BITS       = 12;
    localparam int MEM_WORDS       = 4096;               // full 12-bit address space
    localparam int TS_CYCLES       = 4;                  // clocks held in each of ts1..ts4
    localparam int CYCLE_CLOCKS    = 1 + 4 * TS_CYCLES;  // idle clock plus four time states
    localparam int AUTO_INDEX_PAGE = 1;                  // ma[11:3] value of 0010..0017

    typedef logic [WORD_BITS-1:0] word_t;

    // group 2 opr word with the hlt bit set and the group 3 bit clear
    localparam word_t HLT_MASK = 12'o7403;
    localparam word_t HLT_CODE = 12'o7402;

    // ir contents, straight from mb[11:9]
    typedef enum logic [2:0] {
        OP_AND = 3'd0,
        OP_TAD = 3'd1,
        OP_ISZ = 3'd2,
        OP_DCA = 3'd3,
        OP_JMS = 3'd4,
        OP_JMP = 3'd5,
        OP_IOT = 3'd6,  // executes as a no-op here
        OP_OPR = 3'd7
    } opcode_t;

    // what the current memory cycle is for
    typedef enum logic [2:0] {
        MS_HALT  = 3'd0,
        MS_FETCH = 3'd1,
        MS_DEFER = 3'd2,
        MS_EXEC  = 3'd3,
        MS_DEPOS = 3'd4,
        MS_EXAM  = 3'd5
    } majorState_t;

    typedef enum logic [2:0] {
        TS_IDLE = 3'd0,
        TS_1    = 3'd1,   // read core into mb
        TS_2    = 3'd2,   // modify mb
        TS_3    = 3'd3,   // write mb back
        TS_4    = 3'd4    // update ac, link, pc, ma
    } timeState_t;

    typedef enum logic [2:0] {
        CMD_NONE      = 3'd0,
        CMD_LOAD_ADDR = 3'd1,
        CMD_EXAMINE   = 3'd2,
        CMD_DEPOSIT   = 3'd3,
        CMD_CONTINUE  = 3'd4,
        CMD_START     = 3'd5
    } consoleCmd_t;

endpackage

//--- hdl/pdp8ConsoleSwitches.sv
// front-panel momentary switch sampler, turns each switch release into a one-clock command
module pdp8ConsoleSwitches
    import pdp8Pkg::*;
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic        i_loadAddr,
    input  logic        i_examine,
    input  logic        i_deposit,
    input  logic        i_continue,
    input  logic        i_start,
    output consoleCmd_t o_cmd
);

    logic [4:0] levelNow;   // ldad, exam, dep, cont, start
    logic [4:0] levelLast;  // same order, one clock older
    logic [4:0] released;   // was up last clock, down now

    assign levelNow = {i_loadAddr, i_examine, i_deposit, i_continue, i_start};
    assign released = levelLast & ~levelNow;

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            levelLast <= '0;
            o_cmd     <= CMD_NONE;
        end else begin
            levelLast <= levelNow;
            // fixed priority when released together
            if (released[4])      o_cmd <= CMD_LOAD_ADDR;
            else if (released[3]) o_cmd <= CMD_EXAMINE;
            else if (released[2]) o_cmd <= CMD_DEPOSIT;
            else if (released[1]) o_cmd <= CMD_CONTINUE;
            else if (released[0]) o_cmd <= CMD_START;
            else                  o_cmd <= CMD_NONE;
        end
    end

    // a command is a single-clock pulse, the processor never sees it twice
    assert property (@(posedge CLOCK) disable iff (RESET)
        (o_cmd != CMD_NONE) |=> (o_cmd == CMD_NONE));

endmodule

//--- hdl/pdp8TimeStates.sv
// memory cycle sequencer, one pulse on i_begin walks ts1 through ts4 and back to idle
module pdp8TimeStates
    import pdp8Pkg::*;
(
    input  logic       CLOCK,
    input  logic       RESET,
    input  logic       i_begin,
    output timeState_t o_timeState,
    output logic       o_stateEnd
);

    localparam int CNT_BITS = $clog2(TS_CYCLES);

    logic [CNT_BITS-1:0] cycleCount;  // clocks spent so far in this time state

    // last clock of a busy time state
    assign o_stateEnd = (o_timeState != TS_IDLE) &&
                        (cycleCount == CNT_BITS'(TS_CYCLES - 1));

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            o_timeState <= TS_IDLE;
            cycleCount  <= '0;
        end else if (o_timeState == TS_IDLE) begin
            cycleCount <= '0;
            if (i_begin) begin
                o_timeState <= TS_1;
            end
        end else if (o_stateEnd) begin
            cycleCount <= '0;
            case (o_timeState)
                TS_1:    o_timeState <= TS_2;
                TS_2:    o_timeState <= TS_3;
                TS_3:    o_timeState <= TS_4;
                default: o_timeState <= TS_IDLE;  // ts4 done, cycle over
            endcase
        end else begin
            cycleCount <= cycleCount + 1'b1;
        end
    end

    // only one memory cycle in flight
    assert property (@(posedge CLOCK) disable iff (RESET)
        i_begin |-> (o_timeState == TS_IDLE));

endmodule

//--- hdl/pdp8CoreMemory.sv
// 4k word core store, registered read at ma and write of mb on the ts3 end strobe
module pdp8CoreMemory
    import pdp8Pkg::*;
(
    input  logic  CLOCK,
    input  word_t i_addr,
    input  word_t i_writeData,
    input  logic  i_write,
    output word_t o_readData
);

    word_t core [MEM_WORDS];  // should map onto block ram

    always_ff @(posedge CLOCK) begin
        if (i_write) begin
            core[i_addr] <= i_writeData;
        end
        o_readData <= core[i_addr];  // ma is steady all cycle, so valid well before ts1 end
    end

endmodule

//--- hdl/pdp8Operate.sv
// operate instruction datapath, group 1 ac/link results and group 2 skip and ac from mb
module pdp8Operate
    import pdp8Pkg::*;
(
    input  word_t i_instr,       // opr word sitting in mb
    input  word_t i_ac,
    input  logic  i_link,
    input  word_t i_switchReg,
    output word_t o_group1Ac,
    output logic  o_group1Link,
    output word_t o_group2Ac,
    output logic  o_group2Skip
);

    word_t clrAc;     // after cla
    logic  clrLink;   // after cll
    word_t rawAc;     // after cma and iac
    logic  rawLink;   // after cml and iac carry
    logic  anySkip;   // or of selected group 2 tests

    ////////////////////////////////////////
    // group 1
    always_comb begin
        clrAc   = i_instr[7] ? '0 : i_ac;
        clrLink = i_instr[6] ? 1'b0 : i_link;
        // iac carry out toggles the link
        {rawLink, rawAc} = {clrLink ^ i_instr[4], clrAc ^ {WORD_BITS{i_instr[5]}}}
                         + 13'(i_instr[0]);
        case (i_instr[3:1])
            3'b001: {o_group1Link, o_group1Ac} = {rawLink, rawAc[5:0], rawAc[11:6]};  // bsw
            3'b010: {o_group1Link, o_group1Ac} = {rawAc, rawLink};                    // ral
            3'b011: {o_group1Link, o_group1Ac} = {rawAc[10:0], rawLink, rawAc[11]};   // rtl
            3'b100: {o_group1Link, o_group1Ac} = {rawAc[0], rawLink, rawAc[11:1]};    // rar
            3'b101: {o_group1Link, o_group1Ac} = {rawAc[1:0], rawLink, rawAc[11:2]};  // rtr
            default: begin
                o_group1Link = rawLink;  // no rotate
                o_group1Ac   = rawAc;
            end
        endcase
    end

    ////////////////////////////////////////
    // group 2
    assign anySkip = (i_instr[6] & i_ac[WORD_BITS-1]) |  // sma
                     (i_instr[5] & (i_ac == '0)) |       // sza
                     (i_instr[4] & i_link);              // snl

    assign o_group2Skip = anySkip ^ i_instr[3];  // reverse sense gives spa, sna, szl

    // cla first, then osr ors in the switches
    assign o_group2Ac = (i_instr[7] ? '0 : i_ac) | (i_instr[2] ? i_switchReg : '0);

endmodule

//--- hdl/pdp8MajorStates.sv
// processor registers and major-state control that run memory-reference and console cycles
module pdp8MajorStates
    import pdp8Pkg::*;
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  consoleCmd_t i_cmd,
    input  logic        i_stop,
    input  logic        i_step,
    input  word_t       i_switchReg,
    input  timeState_t  i_timeState,
    input  logic        i_stateEnd,
    input  word_t       i_memData,
    input  word_t       i_group1Ac,
    input  logic        i_group1Link,
    input  word_t       i_group2Ac,
    input  logic        i_group2Skip,
    output logic        o_begin,
    output logic        o_memWrite,
    output word_t       o_ac,
    output word_t       o_ma,
    output word_t       o_mb,
    output logic        o_link,
    output opcode_t     o_ir,
    output majorState_t o_majorState,
    output logic        o_run
);

    word_t       pc;
    majorState_t nextState;    // decided at ts3 end
    majorState_t fetchOrHalt;  // where a finished instruction goes
    word_t       effAddr;      // page zero or current page operand
    word_t       tadAc;
    logic        tadLink;
    logic        haltReq;
    logic        ts1End, ts2End, ts3End, ts4End;
    logic        consoleIdle;  // halted between cycles so the console may act
    logic        running;      // cycle belongs to a program and not the console
    word_t       pcNext, maNext, acNext;
    logic        linkNext;

    assign ts1End = i_stateEnd && (i_timeState == TS_1);
    assign ts2End = i_stateEnd && (i_timeState == TS_2);
    assign ts3End = i_stateEnd && (i_timeState == TS_3);
    assign ts4End = i_stateEnd && (i_timeState == TS_4);

    assign o_memWrite  = ts3End;  // mb back to core
    assign o_run       = o_majorState != MS_HALT;
    assign consoleIdle = (o_majorState == MS_HALT) && (i_timeState == TS_IDLE);
    assign running     = (o_majorState == MS_FETCH) || (o_majorState == MS_DEFER) ||
                         (o_majorState == MS_EXEC);

    assign effAddr = {o_mb[7] ? o_ma[11:7] : 5'b0, o_mb[6:0]};  // ma still holds instr address
    assign {tadLink, tadAc} = {o_link, o_ac} + {1'b0, o_mb};    // carry complements link

    // stop/step panel switches or a fetched hlt end the instruction stream
    assign haltReq = i_stop | i_step |
                     ((o_majorState == MS_FETCH) && ((o_mb & HLT_MASK) == HLT_CODE));
    assign fetchOrHalt = haltReq ? MS_HALT : MS_FETCH;

    ////////////////////////////////////////
    // ts4 results registered at ts4 end
    always_comb begin
        pcNext   = pc;
        maNext   = o_mb;  // defer leaves the pointer in mb
        acNext   = o_ac;
        linkNext = o_link;
        case (o_majorState)
            MS_FETCH: begin
                maNext = effAddr;
                if (o_ir == OP_JMP && !o_mb[8]) pcNext = effAddr;  // direct jmp
                if (o_ir == OP_OPR && !o_mb[8]) begin
                    acNext   = i_group1Ac;
                    linkNext = i_group1Link;
                end else if (o_ir == OP_OPR && !o_mb[0]) begin
                    acNext = i_group2Ac;
                    if (i_group2Skip) pcNext = pc + 1'b1;
                end
            end
            MS_DEFER: if (o_ir == OP_JMP) pcNext = o_mb;  // indirect jmp
            MS_EXEC: begin
                case (o_ir)
                    OP_AND: acNext = o_ac & o_mb;
                    OP_TAD: {linkNext, acNext} = {tadLink, tadAc};
                    OP_ISZ: if (o_mb == '0) pcNext = pc + 1'b1;  // mb already incremented
                    OP_DCA: acNext = '0;
                    OP_JMS: pcNext = o_ma + 1'b1;                // first word of subroutine
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            o_ac         <= '0;
            o_link       <= 1'b0;
            pc           <= '0;
            o_ma         <= '0;
            o_mb         <= '0;
            o_ir         <= OP_AND;
            o_majorState <= MS_HALT;
            nextState    <= MS_HALT;
            o_begin      <= 1'b0;
        end else begin
            o_begin <= consoleIdle && (i_cmd != CMD_NONE);

            ////////////////////////////////////////
            // console acts only while halted and idle
            if (consoleIdle) begin
                case (i_cmd)
                    CMD_LOAD_ADDR: begin
                        pc           <= i_switchReg;
                        o_ma         <= i_switchReg;
                        o_majorState <= MS_EXAM;  // one read cycle shows the word
                    end
                    CMD_EXAMINE, CMD_DEPOSIT: begin
                        o_ma         <= pc;
                        pc           <= pc + 1'b1;
                        o_majorState <= (i_cmd == CMD_DEPOSIT) ? MS_DEPOS : MS_EXAM;
                    end
                    CMD_CONTINUE: begin
                        o_ma         <= pc;
                        o_majorState <= MS_FETCH;
                    end
                    CMD_START: begin
                        o_ac         <= '0;
                        o_link       <= 1'b0;
                        o_ma         <= pc;
                        o_majorState <= MS_FETCH;
                    end
                    default: ;
                endcase
            end

            if (ts1End) o_mb <= i_memData;

            // mb modify step
            if (ts2End) begin
                case (o_majorState)
                    MS_FETCH: begin
                        o_ir <= opcode_t'(o_mb[11:9]);
                        pc   <= pc + 1'b1;
                    end
                    MS_DEFER: if (o_ma[11:3] == 9'(AUTO_INDEX_PAGE)) o_mb <= o_mb + 1'b1;
                    MS_EXEC: begin
                        case (o_ir)
                            OP_ISZ:  o_mb <= o_mb + 1'b1;
                            OP_DCA:  o_mb <= o_ac;
                            OP_JMS:  o_mb <= pc;  // return address
                            default: ;
                        endcase
                    end
                    MS_DEPOS: o_mb <= i_switchReg;
                    default: ;
                endcase
            end

            if (ts3End) begin
                case (o_majorState)
                    MS_FETCH: begin
                        if (o_ir <= OP_JMS)                 nextState <= o_mb[8] ? MS_DEFER : MS_EXEC;
                        else if (o_ir == OP_JMP && o_mb[8]) nextState <= MS_DEFER;
                        else                                nextState <= fetchOrHalt;
                    end
                    MS_DEFER: nextState <= (o_ir == OP_JMP) ? fetchOrHalt : MS_EXEC;
                    MS_EXEC:  nextState <= fetchOrHalt;
                    default:  nextState <= MS_HALT;  // console cycles run once
                endcase
            end

            if (ts4End) begin
                o_ac         <= acNext;
                o_link       <= linkNext;
                pc           <= pcNext;
                o_majorState <= nextState;
                o_begin      <= nextState != MS_HALT;
                case (nextState)
                    MS_FETCH:          o_ma <= pcNext;
                    MS_DEFER, MS_EXEC: o_ma <= maNext;
                    default: if (running) o_ma <= pcNext;  // program halt puts pc on the ma lamps
                endcase
            end
        end
    end

    // write strobe is always followed by ts4 of the same cycle
    assert property (@(posedge CLOCK) disable iff (RESET)
        o_memWrite |=> (i_timeState == TS_4));

    // ma only moves between memory cycles and stays steady for the core through ts1 to ts3
    assert property (@(posedge CLOCK) disable iff (RESET)
        !$stable(o_ma) |-> (i_timeState == TS_IDLE));

endmodule

//--- hdl/pdp8Top.sv
// pdp-8/l style processor top, console switches and lamps around the core and control
module pdp8Top
    import pdp8Pkg::*;
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic        i_loadAddr,
    input  logic        i_examine,
    input  logic        i_deposit,
    input  logic        i_continue,
    input  logic        i_start,
    input  logic        i_stop,
    input  logic        i_step,
    input  word_t       i_switchReg,
    output word_t       o_ac,
    output logic        o_link,
    output word_t       o_ma,
    output word_t       o_mb,
    output opcode_t     o_ir,
    output majorState_t o_majorState,
    output logic        o_run
);

    consoleCmd_t cmd;
    timeState_t  timeState;
    logic        stateEnd, cycleBegin, memWrite;
    word_t       memData;
    word_t       group1Ac, group2Ac;
    logic        group1Link, group2Skip;

    pdp8ConsoleSwitches u_switches (
        .CLOCK, .RESET, .i_loadAddr, .i_examine, .i_deposit, .i_continue, .i_start,
        .o_cmd(cmd)
    );

    pdp8TimeStates u_timeStates (
        .CLOCK, .RESET, .i_begin(cycleBegin), .o_timeState(timeState), .o_stateEnd(stateEnd)
    );

    pdp8CoreMemory u_core (
        .CLOCK, .i_addr(o_ma), .i_writeData(o_mb), .i_write(memWrite), .o_readData(memData)
    );

    pdp8Operate u_operate (
        .i_instr(o_mb), .i_ac(o_ac), .i_link(o_link), .i_switchReg,
        .o_group1Ac(group1Ac), .o_group1Link(group1Link),
        .o_group2Ac(group2Ac), .o_group2Skip(group2Skip)
    );

    pdp8MajorStates u_majorStates (
        .CLOCK, .RESET, .i_cmd(cmd), .i_stop, .i_step, .i_switchReg,
        .i_timeState(timeState), .i_stateEnd(stateEnd), .i_memData(memData),
        .i_group1Ac(group1Ac), .i_group1Link(group1Link),
        .i_group2Ac(group2Ac), .i_group2Skip(group2Skip),
        .o_begin(cycleBegin), .o_memWrite(memWrite),
        .o_ac, .o_ma, .o_mb, .o_link, .o_ir, .o_majorState, .o_run
    );

endmodule

//--- tb/tbPdp8Model.svh
// instruction-set model, program generator and compare tasks that the testbench top includes
localparam int KIND_MEMREF = 0;  // and/tad/isz/dca with forward jmp/jms
localparam int KIND_AUTO   = 1;  // indirect through 0010..0017 only
localparam int KIND_GROUP1 = 2;
localparam int KIND_GROUP2 = 3;
localparam int KIND_LONG   = 4;  // long group 1 run for stop/continue

word_t mem [MEM_WORDS];  // model core
word_t mAc, mPc, runSr;
logic  mLink;
bit    stray;            // program touched core outside 0000..0377

function automatic word_t readMem(input word_t a);
    if (a >= 12'o400) stray = 1'b1;
    return mem[a];
endfunction

function automatic void writeMem(input word_t a, input word_t d);
    if (a >= 12'o400) stray = 1'b1;
    mem[a] = d;
endfunction

////////////////////////////////////////
// one instruction executed by the instruction-set rules
task automatic execOne(output bit hlt);
    word_t ins, ea, ptr, data;
    logic [12:0] sum;
    logic skip;
    hlt = 1'b0;
    ins = readMem(mPc);
    ea  = {ins[7] ? mPc[11:7] : 5'b0, ins[6:0]};  // page zero or current page
    mPc = mPc + 12'd1;
    if (ins[11:9] < 3'o6 && ins[8]) begin
        ptr = readMem(ea);
        if (ea >= 12'o10 && ea <= 12'o17) begin  // auto-index
            ptr = ptr + 12'd1;
            writeMem(ea, ptr);
        end
        ea = ptr;
    end
    case (ins[11:9])
        3'o0: mAc = mAc & readMem(ea);
        3'o1: begin
            sum = {1'b0, mAc} + {1'b0, readMem(ea)};
            mAc = sum[11:0];
            if (sum[12]) mLink = ~mLink;  // carry out flips link
        end
        3'o2: begin
            data = readMem(ea) + 12'd1;
            writeMem(ea, data);
            if (data == '0) mPc = mPc + 12'd1;
        end
        3'o3: begin
            writeMem(ea, mAc);
            mAc = '0;
        end
        3'o4: begin
            writeMem(ea, mPc);  // return address
            mPc = ea + 12'd1;
        end
        3'o5: mPc = ea;
        3'o7: begin
            if (!ins[8]) begin
                if (ins[7]) mAc = '0;
                if (ins[6]) mLink = 1'b0;
                if (ins[5]) mAc = ~mAc;
                if (ins[4]) mLink = ~mLink;
                if (ins[0]) begin
                    mAc = mAc + 12'd1;
                    if (mAc == '0) mLink = ~mLink;
                end
                case (ins[3:1])
                    3'd1: mAc = {mAc[5:0], mAc[11:6]};  // byte swap
                    3'd2, 3'd3: for (int k = 0; k < (ins[1] ? 2 : 1); k++)
                        {mLink, mAc} = {mAc, mLink};
                    3'd4, 3'd5: for (int k = 0; k < (ins[1] ? 2 : 1); k++)
                        {mLink, mAc} = {mAc[0], mLink, mAc[11:1]};
                    default: ;
                endcase
            end else if (!ins[0]) begin
                skip = (ins[6] && mAc[11]) || (ins[5] && mAc == '0) || (ins[4] && mLink);
                if (ins[3]) skip = !skip;
                if (ins[7]) mAc = '0;
                if (ins[2]) mAc = mAc | runSr;  // osr
                if (skip) mPc = mPc + 12'd1;
                hlt = ins[1];
            end
        end
        default: ;  // iot does nothing
    endcase
endtask

task automatic runModel(output bit ok);
    bit hlt;
    int n;
    stray = 1'b0;
    hlt   = 1'b0;
    n     = 0;
    while (!hlt && n < 64) begin
        execOne(hlt);
        n++;
    end
    ok = hlt && !stray;
endtask

////////////////////////////////////////
// program generator with code at 0200, pointers at 0010..0077 and data at 0100..0177 and 0300..0377
function automatic word_t makeInstr(input int kind, input int pos, input int len);
    int r, op, target;
    r  = $random(seed);
    op = (r >> 12) & 7;
    if (kind == KIND_GROUP1 || kind == KIND_LONG) return 12'o7000 | 12'(r & 'o377);
    if (kind == KIND_GROUP2) return 12'o7400 | 12'(r & 'o374);  // no hlt and no group 3
    if (kind == KIND_MEMREF && op >= 6 && pos < len - 1) begin
        target = pos + 1 + ((r >> 16) & 'hffff) % (len - pos);  // forward only
        return {(op[0] ? 3'o5 : 3'o4), 2'b01, 7'(target)};
    end
    if (kind == KIND_AUTO) return {3'(op & 3), 2'b10, 7'(8 + (r & 7))};
    case ((r >> 20) & 3)
        0:       return {3'(op & 3), 2'b10, 7'(8 + (r & 'hff) % 56)};
        1:       return {3'(op & 3), 2'b00, 7'('o100 + (r & 'o77))};
        default: return {3'(op & 3), 2'b01, 7'('o100 + (r & 'o77))};
    endcase
endfunction

task automatic genProgram(input int kind);
    int len;
    for (int a = 0; a < 'o400; a++) mem[a] = word_t'($random(seed));
    for (int a = 'o10; a < 'o100; a++) mem[a] = 12'o300 + 12'($random(seed) & 31);
    for (int a = 'o200; a < 'o300; a++) mem[a] = HLT_CODE;  // skipped hlt lands on another
    len = (kind == KIND_LONG) ? 50 : 8 + ($random(seed) & 15);
    for (int p = 0; p < len; p++) mem['o200 + p] = makeInstr(kind, p, len);
    runSr = word_t'($random(seed));
endtask

////////////////////////////////////////
// compare tasks
task automatic stopRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
endtask

task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %04o expected %04o", $time, name, got, exp);
        stopRun();
    end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        stopRun();
    end
endtask

task automatic checkState(input string name, input majorState_t got, input majorState_t exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        stopRun();
    end
endtask

task automatic checkOpcode(input string name, input opcode_t got, input opcode_t exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        stopRun();
    end
endtask

//--- tb/tbPdp8.sv
// self-checking testbench driving the front panel and checking lamps against an isa model
module tbPdp8
    import pdp8Pkg::*;
();

    localparam int SW_LOAD  = 0;
    localparam int SW_EXAM  = 1;
    localparam int SW_DEP   = 2;
    localparam int SW_CONT  = 3;
    localparam int SW_START = 4;
    localparam int RUN_LIMIT = 256 * CYCLE_CLOCKS;  // longest program plus margin

    logic        CLOCK, RESET;
    logic        loadAddr, examine, deposit, cont, start, stop, step;
    word_t       swReg;
    word_t       ac, ma, mb;
    logic        link, run;
    opcode_t     ir;
    majorState_t mState;
    integer      seed = 42;

    `include "tbPdp8Model.svh"

    pdp8Top i_dut (
        .CLOCK, .RESET, .i_loadAddr(loadAddr), .i_examine(examine), .i_deposit(deposit),
        .i_continue(cont), .i_start(start), .i_stop(stop), .i_step(step), .i_switchReg(swReg),
        .o_ac(ac), .o_link(link), .o_ma(ma), .o_mb(mb), .o_ir(ir),
        .o_majorState(mState), .o_run(run)
    );

    always #4 CLOCK = ~CLOCK;

    ////////////////////////////////////////
    // front panel
    task automatic pressSwitch(input int which);
        @(negedge CLOCK);
        case (which)
            SW_LOAD: loadAddr = 1'b1;
            SW_EXAM: examine  = 1'b1;
            SW_DEP:  deposit  = 1'b1;
            SW_CONT: cont     = 1'b1;
            default: start    = 1'b1;
        endcase
        repeat (3) @(negedge CLOCK);  // held a few clocks and acted on at release
        {loadAddr, examine, deposit, cont, start} = '0;
    endtask

    // polls the run lamp until it shows the wanted level
    task automatic waitForState(input bit toHalt, input int limit, input string what);
        int n;
        n = 0;
        while (run !== !toHalt) begin
            @(negedge CLOCK);
            n++;
            if (n > limit) begin
                $display("timeout, %s", what);
                stopRun();
            end
        end
    endtask

    task automatic consoleCycle(input int which);
        pressSwitch(which);
        waitForState(1'b0, 8, "processor never left halt after a switch release");
        waitForState(1'b1, RUN_LIMIT, "processor never halted");
    endtask

    ////////////////////////////////////////
    // one generated program is deposited, run and checked
    task automatic runProgram(input int kind, input bit stopMidway);
        word_t image [256];
        bit ok;
        int tries;
        ok    = 1'b0;
        tries = 0;
        while (!ok) begin
            genProgram(kind);
            for (int a = 0; a < 256; a++) image[a] = mem[a];
            mAc   = '0;
            mLink = 1'b0;
            mPc   = 12'o200;
            runModel(ok);
            tries++;
            if (tries > 100) begin
                $display("program generator found no program that halts");
                stopRun();
            end
        end
        swReg = '0;
        consoleCycle(SW_LOAD);
        for (int a = 0; a < 256; a++) begin
            swReg = image[a];
            consoleCycle(SW_DEP);
        end
        swReg = 12'o200;
        consoleCycle(SW_LOAD);
        swReg = runSr;  // osr reads this
        if (stopMidway) begin
            pressSwitch(SW_START);
            waitForState(1'b0, 8, "start did not begin a fetch");
            repeat (5 * CYCLE_CLOCKS) @(negedge CLOCK);
            stop = 1'b1;
            waitForState(1'b1, 4 * CYCLE_CLOCKS, "stop switch did not halt the processor");
            checkState("o_majorState", mState, MS_HALT);
            stop = 1'b0;
            consoleCycle(SW_CONT);
        end else begin
            consoleCycle(SW_START);
        end
        checkWord("o_ac", ac, mAc);
        checkBit("o_link", link, mLink);
        checkWord("o_ma", ma, mPc);  // pc on the ma lamps at halt
        checkOpcode("o_ir", ir, OP_OPR);  // last fetch is the hlt or a group 1 word at a stop
        swReg = '0;
        consoleCycle(SW_LOAD);
        for (int a = 0; a < 256; a++) begin
            consoleCycle(SW_EXAM);
            checkWord("o_mb", mb, mem[a]);
        end
    endtask

    initial begin
        word_t base;
        word_t words [8];
        CLOCK = 1'b0;
        RESET = 1'b1;
        {loadAddr, examine, deposit, cont, start, stop, step} = '0;
        swReg = '0;
        repeat (4) @(negedge CLOCK);
        RESET = 1'b0;
        @(negedge CLOCK);

        // load address then deposit and examine back
        base  = word_t'($random(seed));
        swReg = base;
        consoleCycle(SW_LOAD);
        checkWord("o_ma", ma, base);
        for (int k = 0; k < 8; k++) begin
            words[k] = word_t'($random(seed));
            swReg    = words[k];
            consoleCycle(SW_DEP);
        end
        swReg = base;
        consoleCycle(SW_LOAD);
        for (int k = 0; k < 8; k++) begin
            consoleCycle(SW_EXAM);
            checkWord("o_ma", ma, base + 12'(k));
            checkWord("o_mb", mb, words[k]);
        end

        for (int i = 0; i < 4; i++) runProgram(KIND_MEMREF, 1'b0);
        for (int i = 0; i < 3; i++) runProgram(KIND_AUTO, 1'b0);
        for (int i = 0; i < 4; i++) runProgram(KIND_GROUP1, 1'b0);
        for (int i = 0; i < 4; i++) runProgram(KIND_GROUP2, 1'b0);
        runProgram(KIND_LONG, 1'b1);  // stop then continue

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- pdp8Console.f
+incdir+tb
hdl/pdp8Pkg.sv
hdl/pdp8ConsoleSwitches.sv
hdl/pdp8TimeStates.sv
hdl/pdp8CoreMemory.sv
hdl/pdp8Operate.sv
hdl/pdp8MajorStates.sv
hdl/pdp8Top.sv
tb/tbPdp8.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbPdp8
FILELIST = pdp8Console.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check the log for the pass message"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
